//--- filelist.f
src/skin_box_pkg.sv
src/yuv_capture.sv
src/chroma_classifier.sv
src/region_box_tracker.sv
src/skin_box_top.sv
testbench/skin_box_chk.sv
testbench/skin_box_tb.sv

//--- run_sim.sh
#!/bin/bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module skin_box_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vskin_box_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- src/chroma_classifier.sv
`timescale 1ns/1ns

module chroma_classifier
    import skin_box_pkg::*;
(
    input  chroma_t chroma_u,
    input  chroma_t chroma_v,
    output logic    box_hit,
    output logic    skin_wide
);

    logic u_in_box;
    logic v_in_box;
    logic u_in_wide;
    logic v_in_wide;

    // Inclusive range test
    function automatic logic in_window(
        input chroma_t value,
        input chroma_t lo,
        input chroma_t hi
    );
        logic above_lo;
        logic below_hi;
        above_lo = (value >= lo);
        below_hi = (value <= hi);
        return above_lo && below_hi;
    endfunction

    ////////////////////////////////////////
    // Narrow window
    ////////////////////////////////////////

    assign u_in_box = in_window(chroma_u, BOX_U_MIN, BOX_U_MAX);
    assign v_in_box = in_window(chroma_v, BOX_V_MIN, BOX_V_MAX);
    assign box_hit  = u_in_box && v_in_box;

    ////////////////////////////////////////
    // Wide window
    ////////////////////////////////////////

    assign u_in_wide = in_window(chroma_u, WIDE_U_MIN, WIDE_U_MAX);
    assign v_in_wide = in_window(chroma_v, WIDE_V_MIN, WIDE_V_MAX);
    assign skin_wide = u_in_wide && v_in_wide;

endmodule

//--- src/region_box_tracker.sv
`timescale 1ns/1ns

module region_box_tracker
    import skin_box_pkg::*;
#(
    parameter int FRAME_WIDTH = DEF_FRAME_WIDTH,
    parameter int TILE_WIDTH  = DEF_TILE_WIDTH,
    parameter int TILE_HEIGHT = DEF_TILE_HEIGHT
) (
    input  logic   pclk,
    input  logic   reset,
    input  logic   vsync,
    input  logic   sample_strobe,
    input  logic   box_hit,
    input  coord_t x_coord,
    input  coord_t y_coord,
    output coord_t box_min_x [NUM_REGIONS],
    output coord_t box_max_x [NUM_REGIONS],
    output coord_t box_min_y [NUM_REGIONS],
    output coord_t box_max_y [NUM_REGIONS]
);

    // Minimum of an empty box, larger than any real column
    localparam coord_t EMPTY_MIN = coord_t'(FRAME_WIDTH + 1);

    coord_t      tile_col;
    coord_t      tile_row;
    logic        in_grid;
    region_idx_t region_idx;
    logic        update;

    ////////////////////////////////////////
    // Tile decode
    ////////////////////////////////////////

    assign tile_col = coord_t'(x_coord / TILE_WIDTH);
    assign tile_row = coord_t'(y_coord / TILE_HEIGHT);

    assign in_grid = (tile_col < coord_t'(GRID_COLS)) && (tile_row < coord_t'(GRID_ROWS));

    // Row major, region 0 top left
    assign region_idx = region_idx_t'(tile_row * GRID_COLS + tile_col);

    assign update = sample_strobe && box_hit && in_grid;

    ////////////////////////////////////////
    // Per-region min/max registers
    ////////////////////////////////////////

    for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
        logic sel;

        assign sel = update && (region_idx == region_idx_t'(r));

        always_ff @(posedge pclk or posedge reset) begin
            if (reset) begin
                box_min_x[r] <= EMPTY_MIN;
                box_max_x[r] <= '0;
                box_min_y[r] <= EMPTY_MIN;
                box_max_y[r] <= '0;
            end else if (vsync) begin
                box_min_x[r] <= EMPTY_MIN;
                box_max_x[r] <= '0;
                box_min_y[r] <= EMPTY_MIN;
                box_max_y[r] <= '0;
            end else if (sel) begin
                // Grow the box to cover this pixel
                if (x_coord < box_min_x[r]) begin
                    box_min_x[r] <= x_coord;
                end
                if (x_coord > box_max_x[r]) begin
                    box_max_x[r] <= x_coord;
                end
                if (y_coord < box_min_y[r]) begin
                    box_min_y[r] <= y_coord;
                end
                if (y_coord > box_max_y[r]) begin
                    box_max_y[r] <= y_coord;
                end
            end
        end
    end

endmodule

//--- src/skin_box_pkg.sv
package skin_box_pkg;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    // Pixel coordinate, wide enough for 640 columns
    typedef logic [9:0] coord_t;
    typedef logic [7:0] chroma_t;
    typedef logic [3:0] region_idx_t;

    ////////////////////////////////////////
    // Frame and tile geometry
    ////////////////////////////////////////

    localparam int DEF_FRAME_WIDTH  = 640;
    localparam int DEF_FRAME_HEIGHT = 480;
    localparam int DEF_TILE_WIDTH   = 160;
    localparam int DEF_TILE_HEIGHT  = 160;

    localparam int GRID_COLS   = 4;
    localparam int GRID_ROWS   = 3;
    localparam int NUM_REGIONS = GRID_COLS * GRID_ROWS;

    ////////////////////////////////////////
    // Chroma windows
    ////////////////////////////////////////

    // Narrow window for the boxes
    localparam chroma_t BOX_U_MIN = 8'd95;
    localparam chroma_t BOX_U_MAX = 8'd110;
    localparam chroma_t BOX_V_MIN = 8'd145;
    localparam chroma_t BOX_V_MAX = 8'd160;

    // Wide window, flag only
    localparam chroma_t WIDE_U_MIN = 8'd113;
    localparam chroma_t WIDE_U_MAX = 8'd190;
    localparam chroma_t WIDE_V_MIN = 8'd113;
    localparam chroma_t WIDE_V_MAX = 8'd190;

endpackage

//--- src/skin_box_top.sv
`timescale 1ns/1ns

module skin_box_top
    import skin_box_pkg::*;
#(
    parameter int FRAME_WIDTH = DEF_FRAME_WIDTH,
    parameter int TILE_WIDTH  = DEF_TILE_WIDTH,
    parameter int TILE_HEIGHT = DEF_TILE_HEIGHT
) (
    input  logic    pclk,
    input  logic    reset,
    input  logic    vsync,
    input  logic    href,
    input  logic    config_done,
    input  chroma_t cam_data,
    output coord_t  x_coord,
    output coord_t  y_coord,
    output logic    skin_wide,
    output logic    box_hit,
    output coord_t  box_min_x [NUM_REGIONS],
    output coord_t  box_max_x [NUM_REGIONS],
    output coord_t  box_min_y [NUM_REGIONS],
    output coord_t  box_max_y [NUM_REGIONS]
);

    chroma_t chroma_u;
    chroma_t chroma_v;
    logic    sample_strobe;

    ////////////////////////////////////////
    // Byte capture
    ////////////////////////////////////////

    yuv_capture u_capture (
        .pclk          (pclk),
        .reset         (reset),
        .vsync         (vsync),
        .href          (href),
        .config_done   (config_done),
        .cam_data      (cam_data),
        .x_coord       (x_coord),
        .y_coord       (y_coord),
        .chroma_u      (chroma_u),
        .chroma_v      (chroma_v),
        .sample_strobe (sample_strobe)
    );

    chroma_classifier u_classifier (
        .chroma_u  (chroma_u),
        .chroma_v  (chroma_v),
        .box_hit   (box_hit),
        .skin_wide (skin_wide)
    );

    ////////////////////////////////////////
    // Bounding boxes
    ////////////////////////////////////////

    region_box_tracker #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .TILE_WIDTH  (TILE_WIDTH),
        .TILE_HEIGHT (TILE_HEIGHT)
    ) u_tracker (
        .pclk          (pclk),
        .reset         (reset),
        .vsync         (vsync),
        .sample_strobe (sample_strobe),
        .box_hit       (box_hit),
        .x_coord       (x_coord),
        .y_coord       (y_coord),
        .box_min_x     (box_min_x),
        .box_max_x     (box_max_x),
        .box_min_y     (box_min_y),
        .box_max_y     (box_max_y)
    );

endmodule

//--- src/yuv_capture.sv
`timescale 1ns/1ns

module yuv_capture
    import skin_box_pkg::*;
(
    input  logic    pclk,
    input  logic    reset,
    input  logic    vsync,
    input  logic    href,
    input  logic    config_done,
    input  chroma_t cam_data,
    output coord_t  x_coord,
    output coord_t  y_coord,
    output chroma_t chroma_u,
    output chroma_t chroma_v,
    output logic    sample_strobe
);

    typedef enum logic [1:0] {
        s_idle,
        s_write,
        s_end_row
    } state_t;

    state_t     state;
    state_t     state_next;
    logic [1:0] byte_phase;
    logic       byte_valid;
    logic       strobe_q;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (href && config_done) begin
                    state_next = s_write;
                end
            end
            s_write: begin
                if (!href) begin
                    state_next = s_end_row;
                end
            end
            s_end_row: begin
                state_next = href ? s_write : s_idle;
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // First byte of a row is taken straight from idle
    assign byte_valid = href && ((state == s_write) || (state == s_idle && config_done));

    ////////////////////////////////////////
    // Byte phase, counters and latches
    ////////////////////////////////////////

    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            state      <= s_idle;
            byte_phase <= 2'd0;
            x_coord    <= '0;
            y_coord    <= '0;
            chroma_u   <= '0;
            chroma_v   <= '0;
            strobe_q   <= 1'b0;
        end else if (vsync) begin
            state      <= s_idle;
            byte_phase <= 2'd0;
            x_coord    <= '0;
            y_coord    <= '0;
            chroma_u   <= '0;
            chroma_v   <= '0;
            strobe_q   <= 1'b0;
        end else begin
            state    <= state_next;
            strobe_q <= 1'b0;
            if (state == s_end_row) begin
                byte_phase <= 2'd0;
                x_coord    <= '0;
                y_coord    <= y_coord + coord_t'(1);
            end else if (byte_valid) begin
                byte_phase <= byte_phase + 2'd1;
                case (byte_phase)
                    // U byte
                    2'd1: begin
                        chroma_u <= cam_data;
                        x_coord  <= x_coord + coord_t'(1);
                    end
                    // V byte completes the pair
                    2'd3: begin
                        chroma_v <= cam_data;
                        x_coord  <= x_coord + coord_t'(1);
                        strobe_q <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // No pair is reported once the frame is being cleared
    assign sample_strobe = strobe_q && !vsync;

endmodule

//--- testbench/skin_box_chk.sv
`timescale 1ns/1ns

module skin_box_chk
    import skin_box_pkg::*;
(
    input logic   pclk,
    input logic   reset,
    input logic   vsync,
    input logic   end_row,
    input logic   sample_strobe,
    input coord_t x_coord
);

    ////////////////////////////////////////
    // Capture protocol
    ////////////////////////////////////////

    // One strobe per pixel pair
    a_strobe_single: assert property (@(posedge pclk) disable iff (reset)
        sample_strobe |=> !sample_strobe)
    else $error("sample_strobe was high on two consecutive cycles");

    a_row_restart: assert property (@(posedge pclk) disable iff (reset)
        end_row |=> (x_coord == '0))
    else $error("x_coord did not return to zero after the end of a row");

    // Frame clear hides any pair in flight, and no pair follows it at once
    a_quiet_in_vsync: assert property (@(posedge pclk) disable iff (reset)
        vsync |-> !sample_strobe ##1 !sample_strobe)
    else $error("sample_strobe was high during or right after vsync");

endmodule

bind yuv_capture skin_box_chk u_chk (
    .pclk          (pclk),
    .reset         (reset),
    .vsync         (vsync),
    .end_row       (state == s_end_row),
    .sample_strobe (sample_strobe),
    .x_coord       (x_coord)
);

//--- testbench/skin_box_golden.txt
# test name pairs_per_row rows config_done / rect first_pair first_row pairs rows u v
# box region min_x max_x min_y max_y / regions without a box line are expected empty

test single_tile 8 12 1
rect 1 5 2 2 100 150
box 5 4 6 5 6

test cross_tiles 8 12 1
rect 2 2 3 4 95 160
rect 6 10 2 2 110 145
box 1 6 6 2 3
box 2 8 10 2 3
box 5 6 6 4 5
box 6 8 10 4 5
box 11 14 14 10 11

test wide_only 8 12 1
rect 0 0 8 6 113 190
rect 0 6 8 6 150 120

test frame_a 8 12 1
rect 0 1 1 2 100 150
box 0 2 2 1 2

test frame_b 8 12 1
rect 3 9 2 3 105 155
box 10 8 10 9 11

test no_config 8 12 0
rect 0 0 8 12 100 150

//--- testbench/skin_box_tb.sv
`timescale 1ns/1ns

module skin_box_tb
    import skin_box_pkg::*;
();

    localparam int FRAME_WIDTH = 16;
    localparam int TILE_WIDTH  = 4;
    localparam int TILE_HEIGHT = 4;
    localparam int EMPTY_MIN   = FRAME_WIDTH + 1;
    localparam int MAX_TESTS   = 8;
    localparam int MAX_RECTS   = 32;

    logic    pclk;
    logic    reset;
    logic    vsync;
    logic    href;
    logic    config_done;
    chroma_t cam_data;
    coord_t  x_coord;
    coord_t  y_coord;
    logic    skin_wide;
    logic    box_hit;
    coord_t  box_min_x [NUM_REGIONS];
    coord_t  box_max_x [NUM_REGIONS];
    coord_t  box_min_y [NUM_REGIONS];
    coord_t  box_max_y [NUM_REGIONS];

    // Test table filled from the golden file
    string test_name [MAX_TESTS];
    int    test_pairs [MAX_TESTS];
    int    test_rows [MAX_TESTS];
    int    test_cfg [MAX_TESTS];
    int    exp_box [MAX_TESTS][NUM_REGIONS][4];
    int    rect_test [MAX_RECTS];
    int    rect_def [MAX_RECTS][6];
    int    num_tests;
    int    num_rects;

    string cur_name;
    int    errors;
    int    checks;
    int    cycles;
    int    cycle_limit;
    int    seed;

    // Pair waiting for its strobe cycle
    logic  pair_pending;
    int    pend_u;
    int    pend_v;
    int    pend_x;
    int    pend_y;

    skin_box_top #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .TILE_WIDTH  (TILE_WIDTH),
        .TILE_HEIGHT (TILE_HEIGHT)
    ) u_dut (
        .pclk        (pclk),
        .reset       (reset),
        .vsync       (vsync),
        .href        (href),
        .config_done (config_done),
        .cam_data    (cam_data),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .skin_wide   (skin_wide),
        .box_hit     (box_hit),
        .box_min_x   (box_min_x),
        .box_max_x   (box_max_x),
        .box_min_y   (box_min_y),
        .box_max_y   (box_max_y)
    );

    always #20 pclk = ~pclk;

    always @(posedge pclk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference chroma windows
    ////////////////////////////////////////

    function automatic logic narrow_window(input int u, input int v);
        return (u >= 95) && (u <= 110) && (v >= 145) && (v <= 160);
    endfunction

    function automatic logic wide_window(input int u, input int v);
        return (u >= 113) && (u <= 190) && (v >= 113) && (v <= 190);
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("mismatch %0s %0s: expected %0d, actual %0d",
                     cur_name, what, expected, actual);
        end
    endtask

    // Negative index expects every region empty
    task automatic check_boxes(input int t);
        int act [4];
        int e;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            act[0] = int'(box_min_x[r]);
            act[1] = int'(box_max_x[r]);
            act[2] = int'(box_min_y[r]);
            act[3] = int'(box_max_y[r]);
            for (int f = 0; f < 4; f++) begin
                if (t >= 0) begin
                    e = exp_box[t][r][f];
                end else begin
                    e = (f % 2 == 0) ? EMPTY_MIN : 0;
                end
                check_value($sformatf("region %0d %0s_%0s", r, (f % 2 == 0) ? "min" : "max",
                                      (f < 2) ? "x" : "y"), e, act[f]);
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Flags of a pair settle in the cycle after its V byte
    task automatic step();
        @(posedge pclk);
        #2;
        if (pair_pending) begin
            pair_pending = 1'b0;
            check_value("skin_wide", int'(wide_window(pend_u, pend_v)), int'(skin_wide));
            check_value("box_hit", int'(narrow_window(pend_u, pend_v)), int'(box_hit));
            check_value("x_coord", pend_x, int'(x_coord));
            check_value("y_coord", pend_y, int'(y_coord));
        end
    endtask

    task automatic drive_byte(input int b);
        step();
        href     = 1'b1;
        cam_data = chroma_t'(b);
    endtask

    task automatic draw_background(output int u, output int v);
        u = $random(seed) & 255;
        v = $random(seed) & 255;
        while (narrow_window(u, v) || wide_window(u, v)) begin
            u = $random(seed) & 255;
            v = $random(seed) & 255;
        end
    endtask

    task automatic pair_chroma(input int t, input int k, input int row,
                               output int u, output int v);
        logic hit;
        hit = 1'b0;
        u   = 0;
        v   = 0;
        for (int i = 0; i < num_rects; i++) begin
            if (rect_test[i] == t &&
                k >= rect_def[i][0] && k < rect_def[i][0] + rect_def[i][2] &&
                row >= rect_def[i][1] && row < rect_def[i][1] + rect_def[i][3]) begin
                u   = rect_def[i][4];
                v   = rect_def[i][5];
                hit = 1'b1;
            end
        end
        if (!hit) begin
            draw_background(u, v);
        end
    endtask

    task automatic run_frame(input int t);
        int u;
        int v;
        cur_name = test_name[t];
        // Frame gap with vsync clears every box
        step();
        href  = 1'b0;
        vsync = 1'b1;
        step();
        step();
        check_boxes(-1);
        vsync       = 1'b0;
        config_done = (test_cfg[t] != 0);
        step();
        for (int row = 0; row < test_rows[t]; row++) begin
            for (int k = 0; k < test_pairs[t]; k++) begin
                pair_chroma(t, k, row, u, v);
                drive_byte($random(seed) & 255);
                drive_byte(u);
                drive_byte($random(seed) & 255);
                drive_byte(v);
                pend_u       = u;
                pend_v       = v;
                pend_x       = 2 * k + 2;
                pend_y       = row;
                pair_pending = config_done;
            end
            repeat (4) begin
                step();
                href = 1'b0;
            end
        end
        step();
        step();
        check_boxes(t);
    endtask

    task automatic read_golden();
        int    fd;
        int    n;
        int    a [6];
        string line;
        string kw;
        string nm;
        fd = $fopen("testbench/skin_box_golden.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%s", kw);
            if (n == 1 && kw == "test" && num_tests < MAX_TESTS) begin
                n = $sscanf(line, "%s %s %d %d %d", kw, nm, a[0], a[1], a[2]);
                test_name[num_tests]  = nm;
                test_pairs[num_tests] = a[0];
                test_rows[num_tests]  = a[1];
                test_cfg[num_tests]   = a[2];
                for (int r = 0; r < NUM_REGIONS; r++) begin
                    exp_box[num_tests][r][0] = EMPTY_MIN;
                    exp_box[num_tests][r][1] = 0;
                    exp_box[num_tests][r][2] = EMPTY_MIN;
                    exp_box[num_tests][r][3] = 0;
                end
                num_tests++;
            end else if (n == 1 && kw == "rect" && num_tests > 0 && num_rects < MAX_RECTS) begin
                n = $sscanf(line, "%s %d %d %d %d %d %d", kw, a[0], a[1], a[2], a[3], a[4], a[5]);
                rect_test[num_rects] = num_tests - 1;
                for (int i = 0; i < 6; i++) begin
                    rect_def[num_rects][i] = a[i];
                end
                num_rects++;
            end else if (n == 1 && kw == "box" && num_tests > 0) begin
                n = $sscanf(line, "%s %d %d %d %d %d", kw, a[0], a[1], a[2], a[3], a[4]);
                for (int i = 0; i < 4; i++) begin
                    exp_box[num_tests - 1][a[0]][i] = a[i + 1];
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int total_bytes;
        pclk         = 1'b0;
        reset        = 1'b1;
        vsync        = 1'b0;
        href         = 1'b0;
        config_done  = 1'b0;
        cam_data     = '0;
        seed         = 32'h9ed1;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        cycle_limit  = 100000;
        num_tests    = 0;
        num_rects    = 0;
        pair_pending = 1'b0;
        cur_name     = "after_reset";
        read_golden();
        if (num_tests == 0) begin
            errors++;
            $display("No tests could be read from the golden file");
        end
        total_bytes = 0;
        for (int t = 0; t < num_tests; t++) begin
            total_bytes += test_pairs[t] * 4 * test_rows[t];
        end
        cycle_limit = 2 * total_bytes + 64;
        repeat (3) @(posedge pclk);
        #2;
        reset = 1'b0;
        step();
        check_boxes(-1);
        for (int t = 0; t < num_tests; t++) begin
            run_frame(t);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
